// ==== Bender.yml ====
package:
  name: ddbb_cfg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ddbb_cfg_pkg.sv
      - rtl/bar_unit.sv
      - rtl/cfg_regs.sv
      - rtl/irq_chain.sv
      - rtl/resp_delay.sv
      - rtl/ddbb_cfg.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clk_gen.sv
      - test/tb_monitor.sv
      - test/ddbb_cfg_chk.sv
      - test/tb_ddbb_cfg.sv

// ==== ddbb_cfg.f ====
+incdir+rtl
rtl/ddbb_cfg_pkg.sv
rtl/bar_unit.sv
rtl/cfg_regs.sv
rtl/irq_chain.sv
rtl/resp_delay.sv
rtl/ddbb_cfg.sv
test/tb_clk_gen.sv
test/tb_monitor.sv
test/ddbb_cfg_chk.sv
test/tb_ddbb_cfg.sv

// ==== rtl/bar_unit.sv ====
`include "ddbb_cfg_defs.svh"

module bar_unit import ddbb_cfg_pkg::*; #(
	parameter logic [`CFG_ADR_W-1:0] RST_VAL = 32'h1,
	parameter logic [`CFG_ADR_W-1:0] MASK    = 32'h0	// Decoded address bits
) (
	input  logic			clk_i,
	input  logic			rst_i,
	input  logic			wr_i,
	input  logic [3:0]		sel_i,
	input  logic [31:0]		dat_i,
	input  cfg_req_t		req_i,
	output logic [31:0]		bar_o,
	output logic			cs_o
);

	// Sizing write returns the mask, anything else is a byte-lane update
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bar_o <= RST_VAL;
		end else if (wr_i) begin
			if (&sel_i && dat_i == 32'hFFFF_FFFF) begin
				bar_o <= MASK;
			end else begin
				for (int b = 0; b < 4; b++) begin
					if (sel_i[b]) bar_o[b*8 +: 8] <= dat_i[b*8 +: 8];
				end
			end
		end
	end

	// Chip select on a match of every masked bit
	assign cs_o = req_i.cyc && ((req_i.adr ^ bar_o) & MASK) == '0;

endmodule

// ==== rtl/cfg_regs.sv ====
`include "ddbb_cfg_defs.svh"

module cfg_regs import ddbb_cfg_pkg::*; #(
	parameter logic [5:0]	BUS_NUM		= 6'd0,
	parameter logic [4:0]	DEV_NUM		= 5'd0,
	parameter logic [2:0]	FUNC_NUM	= 3'd0,
	parameter logic [15:0]	VENDOR_ID	= 16'h0,
	parameter logic [15:0]	DEVICE_ID	= 16'h0,
	parameter logic [15:0]	SUBSYS_ID	= 16'h0,
	parameter logic [15:0]	SUBSYS_VENDOR_ID = 16'h0,
	parameter logic [31:0]	CLASS_CODE	= 32'h0
) (
	input  logic			clk_i,
	input  logic			rst_i,
	input  logic			cs_i,
	input  cfg_req_t		req_i,
	input  logic [`CFG_NIRQ-1:0]	irq_i,
	input  logic [2:0][31:0]	bar_i,
	output logic			accept_o,
	output logic [2:0]		bar_wr_o,
	output irq_vec_t [`CFG_NIRQ-1:0]	vec_o,
	output logic			int_dis_o,
	output logic [`CFG_DAT_W-1:0]	rd_dat_o
);

	logic [10:0]	wd;		// 64-bit word index
	logic		wr;		// Accepted write
	logic [15:0]	cmd_q;		// Raw command bits as written
	logic [15:0]	cmd;		// With fixed bits applied
	logic [15:0]	stat;

	// ==============================
	// Config cycle decode
	// ==============================
	assign accept_o = cs_i && req_i.cyc
		&& req_i.adr[27:22] == BUS_NUM
		&& req_i.adr[21:17] == DEV_NUM
		&& req_i.adr[16:14] == FUNC_NUM;

	assign wd = req_i.adr[13:3];
	assign wr = accept_o && req_i.we;

	// BAR strobes only when some lane of its half is enabled
	assign bar_wr_o[0] = wr && wd == `CFG_WD_BAR01 && |req_i.sel[3:0];
	assign bar_wr_o[1] = wr && wd == `CFG_WD_BAR01 && |req_i.sel[7:4];
	assign bar_wr_o[2] = wr && wd == `CFG_WD_BAR2 && |req_i.sel[3:0];

	assign cmd = (cmd_q & ~`CFG_CMD_FIX0) | `CFG_CMD_FIX1;
	assign int_dis_o = cmd[10];
	assign stat = `CFG_STAT_FIX | {12'h000, |irq_i, 3'b000};	// Bit 3 is interrupt status

	// Command sits in lanes 4 and 5 of word 0, vectors need a whole half
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmd_q <= `CFG_CMD_RST;
			vec_o <= '0;
		end else if (wr) begin
			if (wd == `CFG_WD_IDENT) begin
				if (req_i.sel[4]) cmd_q[7:0] <= req_i.dat[39:32];
				if (req_i.sel[5]) cmd_q[15:8] <= req_i.dat[47:40];
			end
			if (wd == `CFG_WD_VEC01) begin
				if (&req_i.sel[3:0]) vec_o[0] <= req_i.dat[15:0];
				if (&req_i.sel[7:4]) vec_o[1] <= req_i.dat[47:32];
			end
			if (wd == `CFG_WD_VEC23) begin
				if (&req_i.sel[3:0]) vec_o[2] <= req_i.dat[15:0];
				if (&req_i.sel[7:4]) vec_o[3] <= req_i.dat[47:32];
			end
		end
	end

	// ==============================
	// Read data mux
	// ==============================
	always_comb begin
		rd_dat_o = '0;				// Unmapped words
		case (wd)
			`CFG_WD_IDENT:	rd_dat_o = {stat, cmd, DEVICE_ID, VENDOR_ID};
			`CFG_WD_CLASS:	rd_dat_o = {32'h0, CLASS_CODE};	// Header type 0, no latency timer
			`CFG_WD_BAR01:	rd_dat_o = {bar_i[1], bar_i[0]};
			`CFG_WD_BAR2:	rd_dat_o = {32'hFFFF_FFFF, bar_i[2]};	// BAR3 not implemented
			`CFG_WD_BAR2 + 1: rd_dat_o = '1;	// BAR4 and BAR5 not implemented
			`CFG_WD_SUBSYS:	rd_dat_o = {SUBSYS_ID, SUBSYS_VENDOR_ID, 32'h0};
			`CFG_WD_ROM:	rd_dat_o = '0;		// No expansion ROM
			`CFG_WD_VEC01:	rd_dat_o = {16'h0, vec_o[1], 16'h0, vec_o[0]};
			`CFG_WD_VEC23:	rd_dat_o = {16'h0, vec_o[3], 16'h0, vec_o[2]};
			default:	rd_dat_o = '0;
		endcase
	end

endmodule

// ==== rtl/ddbb_cfg.sv ====
`include "ddbb_cfg_defs.svh"

module ddbb_cfg import ddbb_cfg_pkg::*; #(
	parameter logic [5:0]	BUS_NUM		= 6'd0,
	parameter logic [4:0]	DEV_NUM		= 5'd0,
	parameter logic [2:0]	FUNC_NUM	= 3'd0,
	parameter logic [15:0]	VENDOR_ID	= 16'h0,
	parameter logic [15:0]	DEVICE_ID	= 16'h0,
	parameter logic [15:0]	SUBSYS_ID	= 16'h0,
	parameter logic [15:0]	SUBSYS_VENDOR_ID = 16'h0,
	parameter logic [31:0]	CLASS_CODE	= 32'h0380_0100,	// Class, subclass, prog-if, rev
	parameter logic [31:0]	BAR0_RST	= 32'h1,
	parameter logic [31:0]	BAR1_RST	= 32'h1,
	parameter logic [31:0]	BAR2_RST	= 32'h1,
	parameter logic [31:0]	BAR0_MASK	= 32'h0,
	parameter logic [31:0]	BAR1_MASK	= 32'h0,
	parameter logic [31:0]	BAR2_MASK	= 32'h0
) (
	input  logic			clk_i,
	input  logic			rst_i,
	input  logic			cs_i,
	input  cfg_req_t		req_i,
	input  logic [`CFG_NIRQ-1:0]	irq_i,
	input  irq_vec_t		irq_chain_i,
	output cfg_resp_t		resp_o,
	output irq_vec_t		irq_chain_o,
	output logic			cs_bar0_o,
	output logic			cs_bar1_o,
	output logic			cs_bar2_o
);

	logic				accept;		// Config cycle for this function
	logic [2:0]			bar_wr;		// One write strobe per BAR
	logic [2:0][31:0]		bar;
	irq_vec_t [`CFG_NIRQ-1:0]	vec;
	logic				int_dis;
	logic [`CFG_DAT_W-1:0]		rd_dat;
	cfg_resp_t			rsp_d;		// Response entering the delay line

	cfg_regs #(
		.BUS_NUM(BUS_NUM), .DEV_NUM(DEV_NUM), .FUNC_NUM(FUNC_NUM),
		.VENDOR_ID(VENDOR_ID), .DEVICE_ID(DEVICE_ID),
		.SUBSYS_ID(SUBSYS_ID), .SUBSYS_VENDOR_ID(SUBSYS_VENDOR_ID),
		.CLASS_CODE(CLASS_CODE)
	) i_regs (
		.clk_i, .rst_i, .cs_i, .req_i, .irq_i,
		.bar_i(bar), .accept_o(accept), .bar_wr_o(bar_wr),
		.vec_o(vec), .int_dis_o(int_dis), .rd_dat_o(rd_dat)
	);

	// ==============================
	// Base address registers
	// ==============================
	bar_unit #(.RST_VAL(BAR0_RST), .MASK(BAR0_MASK)) i_bar0 (
		.clk_i, .rst_i, .wr_i(bar_wr[0]), .sel_i(req_i.sel[3:0]),
		.dat_i(req_i.dat[31:0]), .req_i, .bar_o(bar[0]), .cs_o(cs_bar0_o)
	);
	bar_unit #(.RST_VAL(BAR1_RST), .MASK(BAR1_MASK)) i_bar1 (	// Upper half of word 2
		.clk_i, .rst_i, .wr_i(bar_wr[1]), .sel_i(req_i.sel[7:4]),
		.dat_i(req_i.dat[63:32]), .req_i, .bar_o(bar[1]), .cs_o(cs_bar1_o)
	);
	bar_unit #(.RST_VAL(BAR2_RST), .MASK(BAR2_MASK)) i_bar2 (
		.clk_i, .rst_i, .wr_i(bar_wr[2]), .sel_i(req_i.sel[3:0]),
		.dat_i(req_i.dat[31:0]), .req_i, .bar_o(bar[2]), .cs_o(cs_bar2_o)
	);

	irq_chain i_irq (
		.clk_i, .rst_i, .irq_i, .int_dis_i(int_dis), .vec_i(vec),
		.irq_chain_i, .irq_chain_o
	);

	// Reads and end-of-burst writes get an ack, all fields zero otherwise
	always_comb begin
		rsp_d = '0;
		if (accept && (!req_i.we || req_i.erc)) begin
			rsp_d.ack = 1'b1;
			rsp_d.tid = req_i.tid;
			rsp_d.adr = req_i.adr;
			rsp_d.dat = rd_dat;	// Value before this cycle's write
		end
	end

	resp_delay #(.DEPTH(`CFG_ACK_LAT)) i_dly (
		.clk_i, .rst_i, .d_i(rsp_d), .q_o(resp_o)
	);

endmodule

// ==== rtl/ddbb_cfg_defs.svh ====
`ifndef DDBB_CFG_DEFS_SVH
`define DDBB_CFG_DEFS_SVH

// ==============================
// Bus widths
// ==============================
`define CFG_DAT_W	64		// Data path
`define CFG_ADR_W	32		// Byte address
`define CFG_TID_W	13		// Transaction id
`define CFG_SEL_W	8		// One lane per byte

`define CFG_ACK_LAT	16		// Accept edge to ack, in cycles
`define CFG_NIRQ	4		// Interrupt lines
`define CFG_IRQ_HOLD	63		// Hold-off timer terminal count

// Word indexes, address bits 13 to 3
`define CFG_WD_IDENT	0		// Vendor, device, command, status
`define CFG_WD_CLASS	1		// Class code and revision
`define CFG_WD_BAR01	2		// BAR0 low half, BAR1 high half
`define CFG_WD_BAR2	3		// BAR2 low half
`define CFG_WD_SUBSYS	5		// Subsystem ids in the high half
`define CFG_WD_ROM	6		// Expansion ROM base
`define CFG_WD_VEC01	16		// Interrupt vectors 0 and 1
`define CFG_WD_VEC23	17		// Interrupt vectors 2 and 3

`define CFG_CMD_RST	16'h4003	// Memory and IO space on
`define CFG_CMD_FIX0	16'hF8B8	// Reserved, special cycle, MWI, palette snoop
`define CFG_CMD_FIX1	16'h0200	// Fast back-to-back always on
`define CFG_STAT_FIX	16'h02A0	// Medium DEVSEL, fast back-to-back, 66 MHz

`endif

// ==== rtl/ddbb_cfg_pkg.sv ====
`include "ddbb_cfg_defs.svh"

package ddbb_cfg_pkg;

	// ==============================
	// Request from the bus
	// ==============================
	typedef struct packed {
		logic				cyc;	// Bus cycle active
		logic				we;	// Write
		logic				erc;	// Last cycle of a write burst, wants an ack
		logic [`CFG_SEL_W-1:0]		sel;	// Byte lanes
		logic [`CFG_ADR_W-1:0]		adr;
		logic [`CFG_DAT_W-1:0]		dat;
		logic [`CFG_TID_W-1:0]		tid;
	} cfg_req_t;

	// ==============================
	// Response to the bus
	// ==============================
	typedef struct packed {
		logic				ack;	// One-cycle pulse
		logic [`CFG_TID_W-1:0]		tid;	// Echo of request tid
		logic [`CFG_ADR_W-1:0]		adr;	// Echo of request address
		logic [`CFG_DAT_W-1:0]		dat;	// Read data, sampled at accept
	} cfg_resp_t;

	// Message slot on the daisy-chained interrupt bus, zero means empty
	typedef logic [15:0] irq_vec_t;

endpackage

// ==== rtl/irq_chain.sv ====
`include "ddbb_cfg_defs.svh"

module irq_chain import ddbb_cfg_pkg::*; (
	input  logic			clk_i,
	input  logic			rst_i,
	input  logic [`CFG_NIRQ-1:0]	irq_i,
	input  logic			int_dis_i,
	input  irq_vec_t [`CFG_NIRQ-1:0]	vec_i,
	input  irq_vec_t		irq_chain_i,
	output irq_vec_t		irq_chain_o
);

	localparam logic [5:0] HOLD = 6'(`CFG_IRQ_HOLD);

	logic [`CFG_NIRQ-1:0]		pend_q;		// Waiting for an empty slot
	logic [`CFG_NIRQ-1:0][5:0]	tmr_q;		// Hold-off after each insertion
	logic [`CFG_NIRQ-1:0]		ins_oh;		// Line inserted this cycle
	irq_vec_t			ins_vec;	// Next chain value

	// ==============================
	// Slot insertion
	// ==============================
	always_comb begin
		ins_oh = '0;
		ins_vec = irq_chain_i;			// Forward by default
		if (irq_chain_i == '0) begin		// Empty slot
			for (int i = `CFG_NIRQ - 1; i >= 0; i--) begin
				if (pend_q[i]) begin	// Lowest pending wins
					ins_oh = '0;
					ins_oh[i] = 1'b1;
					ins_vec = vec_i[i];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			irq_chain_o <= '0;
			pend_q <= '0;
			for (int i = 0; i < `CFG_NIRQ; i++) tmr_q[i] <= HOLD;	// Ready at once
		end else begin
			irq_chain_o <= ins_vec;
			for (int i = 0; i < `CFG_NIRQ; i++) begin
				if (ins_oh[i]) begin
					pend_q[i] <= 1'b0;	// Clear beats a new request
					tmr_q[i] <= '0;
				end else begin
					if (irq_i[i] && !int_dis_i && tmr_q[i] == HOLD)
						pend_q[i] <= 1'b1;
					if (tmr_q[i] != HOLD)
						tmr_q[i] <= tmr_q[i] + 6'd1;	// Saturates at terminal
				end
			end
		end
	end

endmodule

// ==== rtl/resp_delay.sv ====
`include "ddbb_cfg_defs.svh"

module resp_delay import ddbb_cfg_pkg::*; #(
	parameter int DEPTH = `CFG_ACK_LAT	// Stages, equals ack latency
) (
	input  logic		clk_i,
	input  logic		rst_i,
	input  cfg_resp_t	d_i,
	output cfg_resp_t	q_o
);

	cfg_resp_t stage_q [DEPTH];		// One slot per cycle in flight

	// ==============================
	// Shift pipeline
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < DEPTH; i++) stage_q[i] <= '0;	// No stale acks
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Last stage drives the bus directly
	assign q_o = stage_q[DEPTH-1];

endmodule

// ==== test/ddbb_cfg_chk.sv ====
`include "ddbb_cfg_defs.svh"

module ddbb_cfg_chk import ddbb_cfg_pkg::*; (
	input  logic			clk_i,
	input  logic			rst_i,
	input  logic			ack_d_i,	// Ack entering the delay line
	input  cfg_resp_t		resp_i,
	input  irq_vec_t		chain_i,
	input  irq_vec_t		chain_o_i,
	input  logic [`CFG_NIRQ-1:0]	pend_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;		// Read by the testbench top

	ack_lat: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_d_i |-> ##(`CFG_ACK_LAT) resp_i.ack)
		else begin fail_cnt++; $error("ack missing after accept"); end

	rsp_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		!resp_i.ack |-> resp_i == '0)
		else begin fail_cnt++; $error("response fields set without ack"); end

	// Chain forwarded unchanged while nothing waits
	chain_fwd: assert property (@(posedge clk_i) disable iff (rst_i)
		pend_i == '0 |=> chain_o_i == $past(chain_i))
		else begin fail_cnt++; $error("irq chain not forwarded"); end

endmodule

bind ddbb_cfg ddbb_cfg_chk i_chk (
	.clk_i, .rst_i, .ack_d_i(rsp_d.ack), .resp_i(resp_o),
	.chain_i(irq_chain_i), .chain_o_i(irq_chain_o), .pend_i(i_irq.pend_q)
);

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen #(
	parameter int PERIOD     = 10,		// ns
	parameter int RST_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Reset drops right after the last reset edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

// ==== test/tb_ddbb_cfg.sv ====
`include "ddbb_cfg_defs.svh"

module tb_ddbb_cfg import ddbb_cfg_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int			PERIOD		= 10;
	localparam logic [5:0]		BUS		= 6'h15;
	localparam logic [4:0]		DEV		= 5'h0B;
	localparam logic [2:0]		FUNC		= 3'h5;
	localparam logic [15:0]		VEN_ID		= 16'h5A3C;
	localparam logic [15:0]		DEV_ID		= 16'h7E21;
	localparam logic [15:0]		SUB_ID		= 16'h0042;
	localparam logic [15:0]		SUB_VEN		= 16'h5A3D;
	localparam logic [31:0]		CLASS_CODE	= 32'h0580_0003;
	localparam logic [2:0][31:0]	BAR_RST		= {32'h0000_000C, 32'h1, 32'h0000_0008};
	localparam logic [2:0][31:0]	BAR_MASK	= {32'hFFFF_FF00, 32'hFFF0_0000, 32'hFFFF_F000};
	localparam logic [10:0]		ID_WD [5]	= '{11'd0, 11'd1, 11'd4, 11'd5, 11'd6};
	localparam logic [10:0]		FILT_WD [5]	= '{11'd0, 11'd2, 11'd3, 11'd16, 11'd17};
	localparam int			N_REQ		= 700;	// Upper bound on driven cycles
	localparam longint		WD_CYCLES	= N_REQ * (`CFG_ACK_LAT + 4) + 2000;

	logic			clk, rst, cs;
	cfg_req_t		req;
	logic [`CFG_NIRQ-1:0]	irq;
	irq_vec_t		chain_in, chain_out;
	cfg_resp_t		resp;
	logic [2:0]		cs_bar;
	logic			exp_ack;		// Expected values for the monitor
	cfg_resp_t		exp_resp;
	logic [2:0]		exp_cs;
	irq_vec_t		exp_chain;
	int			mon_err, mon_chk, mon_pend, tb_err;
	logic [31:0]		lfsr;

	// ==============================
	// Reference model state
	// ==============================
	logic [15:0]		m_cmd;			// Raw command bits
	irq_vec_t		m_vec [`CFG_NIRQ];
	logic [31:0]		m_bar [3];
	logic [`CFG_NIRQ-1:0]	m_pend;
	int			m_tmr [`CFG_NIRQ];
	irq_vec_t		m_chain;		// Chain output of the current cycle

	tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(5)) i_clk (.clk_o(clk), .rst_o(rst));

	ddbb_cfg #(
		.BUS_NUM(BUS), .DEV_NUM(DEV), .FUNC_NUM(FUNC), .VENDOR_ID(VEN_ID),
		.DEVICE_ID(DEV_ID), .SUBSYS_ID(SUB_ID), .SUBSYS_VENDOR_ID(SUB_VEN),
		.CLASS_CODE(CLASS_CODE), .BAR0_RST(BAR_RST[0]), .BAR1_RST(BAR_RST[1]),
		.BAR2_RST(BAR_RST[2]), .BAR0_MASK(BAR_MASK[0]), .BAR1_MASK(BAR_MASK[1]),
		.BAR2_MASK(BAR_MASK[2])
	) i_dut (
		.clk_i(clk), .rst_i(rst), .cs_i(cs), .req_i(req), .irq_i(irq),
		.irq_chain_i(chain_in), .resp_o(resp), .irq_chain_o(chain_out),
		.cs_bar0_o(cs_bar[0]), .cs_bar1_o(cs_bar[1]), .cs_bar2_o(cs_bar[2])
	);

	tb_monitor i_mon (
		.clk_i(clk), .rst_i(rst), .resp_i(resp), .cs_bar_i(cs_bar), .chain_i(chain_out),
		.exp_ack_i(exp_ack), .exp_resp_i(exp_resp), .exp_cs_i(exp_cs),
		.exp_chain_i(exp_chain), .err_o(mon_err), .chk_o(mon_chk), .pend_o(mon_pend)
	);

	// Fibonacci LFSR, one step per bit taken
	function automatic logic [63:0] rnd(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};	// Taps 32 22 2 1
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int total_err();
		return mon_err + tb_err + i_dut.i_chk.fail_cnt;
	endfunction

	function automatic cfg_req_t make_req(input logic we, input logic erc,
			input logic [7:0] sel, input logic [10:0] wd, input logic [63:0] dat);
		cfg_req_t r;
		r = '0;
		r.cyc = 1'b1;
		r.we = we;
		r.erc = erc;
		r.sel = sel;
		r.dat = dat;
		r.adr = {4'(rnd(4)), BUS, DEV, FUNC, wd, 3'(rnd(3))};	// Don't-care bits random
		r.tid = 13'(rnd(13));
		return r;
	endfunction

	// Register view before this cycle's write
	function automatic logic [63:0] model_read(input logic [10:0] wd, input logic [3:0] iv);
		logic [15:0] stat;
		stat = `CFG_STAT_FIX | {12'h000, |iv, 3'b000};
		case (wd)
			11'd0:	return {stat, (m_cmd & ~`CFG_CMD_FIX0) | `CFG_CMD_FIX1, DEV_ID, VEN_ID};
			11'd1:	return {32'h0, CLASS_CODE};
			11'd2:	return {m_bar[1], m_bar[0]};
			11'd3:	return {32'hFFFF_FFFF, m_bar[2]};
			11'd4:	return '1;
			11'd5:	return {SUB_ID, SUB_VEN, 32'h0};
			11'd16:	return {16'h0, m_vec[1], 16'h0, m_vec[0]};
			11'd17:	return {16'h0, m_vec[3], 16'h0, m_vec[2]};
			default: return '0;
		endcase
	endfunction

	function automatic void bar_write(input int i, input logic [3:0] s, input logic [31:0] d);
		if (&s && d == 32'hFFFF_FFFF) begin
			m_bar[i] = BAR_MASK[i];		// Sizing
		end else begin
			for (int b = 0; b < 4; b++)
				if (s[b]) m_bar[i][b*8 +: 8] = d[b*8 +: 8];
		end
	endfunction

	function automatic void write_model(input logic [10:0] wd, input logic [7:0] sel,
			input logic [63:0] dat);
		if (wd == 11'd0 && sel[4]) m_cmd[7:0] = dat[39:32];
		if (wd == 11'd0 && sel[5]) m_cmd[15:8] = dat[47:40];
		if (wd == 11'd2) begin
			bar_write(0, sel[3:0], dat[31:0]);
			bar_write(1, sel[7:4], dat[63:32]);
		end
		if (wd == 11'd3) bar_write(2, sel[3:0], dat[31:0]);
		if ((wd == 11'd16 || wd == 11'd17) && &sel[3:0]) m_vec[2*(wd-16)] = dat[15:0];
		if ((wd == 11'd16 || wd == 11'd17) && &sel[7:4]) m_vec[2*(wd-16)+1] = dat[47:32];
	endfunction

	// One clock edge of the interrupt chain
	function automatic void step_irq(input logic [3:0] iv, input irq_vec_t ch);
		logic [15:0] cmd_eff;
		int ins;
		cmd_eff = (m_cmd & ~`CFG_CMD_FIX0) | `CFG_CMD_FIX1;
		ins = -1;
		if (ch == '0) begin
			for (int i = `CFG_NIRQ - 1; i >= 0; i--)
				if (m_pend[i]) ins = i;		// Lowest pending line
		end
		m_chain = (ins >= 0) ? m_vec[ins] : ch;
		for (int i = 0; i < `CFG_NIRQ; i++) begin
			if (i == ins) begin
				m_pend[i] = 1'b0;
				m_tmr[i] = 0;
			end else begin
				if (iv[i] && !cmd_eff[10] && m_tmr[i] == `CFG_IRQ_HOLD) m_pend[i] = 1'b1;
				if (m_tmr[i] != `CFG_IRQ_HOLD) m_tmr[i]++;
			end
		end
	endfunction

	// ==============================
	// Drive one cycle, predict it
	// ==============================
	task automatic drive_cycle(input logic c, input cfg_req_t r, input logic [3:0] iv,
			input irq_vec_t ch);
		logic acc;
		logic [10:0] wd;
		@(negedge clk);
		cs = c;
		req = r;
		irq = iv;
		chain_in = ch;
		wd = r.adr[13:3];
		acc = c && r.cyc && r.adr[27:14] == {BUS, DEV, FUNC};
		exp_ack = acc && (!r.we || r.erc);
		exp_resp = '0;
		if (exp_ack) begin
			exp_resp.ack = 1'b1;
			exp_resp.tid = r.tid;
			exp_resp.adr = r.adr;
			exp_resp.dat = model_read(wd, iv);
		end
		for (int i = 0; i < 3; i++)	// Same bits under the mask
			exp_cs[i] = r.cyc && (r.adr & BAR_MASK[i]) == (m_bar[i] & BAR_MASK[i]);
		exp_chain = m_chain;
		step_irq(iv, ch);
		if (acc && r.we) write_model(wd, r.sel, r.dat);
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, '0, '0, '0);
	endtask

	task automatic read_word(input logic [10:0] wd);
		drive_cycle(1'b1, make_req(1'b0, 1'b0, 8'hFF, wd, '0), '0, '0);
	endtask

	task automatic write_word(input logic [10:0] wd, input logic [7:0] sel,
			input logic [63:0] dat, input logic erc);
		drive_cycle(1'b1, make_req(1'b1, erc, sel, wd, dat), '0, '0);
	endtask

	// Drain outstanding acks, then report
	task automatic finish_test(input string name, input int err0);
		int k;
		k = 0;
		idle(1);			// Last request reaches the monitor queue
		while (mon_pend != 0 && k < `CFG_ACK_LAT + 4) begin
			idle(1);
			k++;
		end
		if (mon_pend != 0) begin
			tb_err++;
			$display("Responses still outstanding at the end of test %s", name);
		end
		$display("[%0t] Test %-10s done, %0d errors", $time, name, total_err() - err0);
	endtask

	// Watchdog
	initial begin
		#(WD_CYCLES * PERIOD);
		$display("Timeout: run did not finish within %0d clock cycles", WD_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int		err0;
		int		k;
		int		low;
		logic		c;
		logic [10:0]	wd;
		logic [3:0]	mask;
		irq_vec_t	v;
		cfg_req_t	r;
		cs = 1'b0;
		req = '0;
		irq = '0;
		chain_in = '0;
		exp_ack = 1'b0;
		exp_resp = '0;
		exp_cs = '0;
		exp_chain = '0;
		tb_err = 0;
		lfsr = 32'h6b7f_94cf;
		m_cmd = `CFG_CMD_RST;
		m_pend = '0;
		m_chain = '0;
		for (int i = 0; i < `CFG_NIRQ; i++) begin
			m_vec[i] = '0;
			m_tmr[i] = `CFG_IRQ_HOLD;	// Timers start at terminal count
		end
		for (int i = 0; i < 3; i++) m_bar[i] = BAR_RST[i];
		wait (!rst);

		// Identity reads, back to back
		err0 = total_err();
		for (int n = 0; n < 40; n++)
			drive_cycle(1'b1, make_req(1'b0, 1'b0, 8'hFF, ID_WD[int'(rnd(3) % 5)], '0),
				4'(rnd(4)), '0);
		finish_test("identity", err0);

		// Command register
		err0 = total_err();
		for (int n = 0; n < 30; n++) begin
			write_word(11'd0, 8'(rnd(8)), rnd(64), 1'(rnd(1)));
			read_word(11'd0);
		end
		finish_test("command", err0);

		// BARs: lane writes, sizing, then decode
		err0 = total_err();
		for (int n = 0; n < 30; n++) begin
			wd = 11'(2 + rnd(1));
			if (rnd(2) == 0) write_word(wd, 8'hFF, '1, 1'b1);
			else write_word(wd, 8'(rnd(8)), rnd(64), 1'b1);
			read_word(wd);
		end
		for (int n = 0; n < 40; n++) begin
			k = int'(rnd(2) % 3);
			r = '0;
			r.cyc = 1'(rnd(1));
			r.tid = 13'(rnd(13));
			if (rnd(1) == 1) r.adr = (m_bar[k] & BAR_MASK[k]) | (32'(rnd(32)) & ~BAR_MASK[k]);
			else r.adr = 32'(rnd(32));
			drive_cycle(1'(rnd(1)), r, '0, '0);
		end
		finish_test("bar", err0);

		// Filtering and writes without erc
		err0 = total_err();
		for (int n = 0; n < 40; n++) begin
			r = make_req(1'(rnd(1)), 1'(rnd(1)), 8'(rnd(8)), FILT_WD[int'(rnd(3) % 5)], rnd(64));
			c = 1'b1;
			case (3'(rnd(3)))
				3'd0:	c = 1'b0;
				3'd1:	r.cyc = 1'b0;
				3'd2:	r.adr[27:22] = ~BUS;
				3'd3:	r.adr[21:17] = ~DEV;
				3'd4:	r.adr[16:14] = ~FUNC;
				default: begin
					r.we = 1'b1;	// Accepted, silent write
					r.erc = 1'b0;
				end
			endcase
			drive_cycle(c, r, '0, '0);
		end
		for (int i = 0; i < 5; i++) read_word(FILT_WD[i]);
		finish_test("filter", err0);

		// Interrupt chain
		err0 = total_err();
		write_word(11'd0, 8'h20, '0, 1'b1);	// Interrupts enabled
		idle(70);				// All hold-off timers at terminal
		for (int i = 0; i < `CFG_NIRQ; i++) begin
			v = {4'(i + 1), 12'(rnd(12))};	// Nonzero and distinct
			write_word(11'(`CFG_WD_VEC01 + i / 2), (i % 2) ? 8'hF0 : 8'h0F,
				{16'h0, v, 16'h0, v}, 1'b1);
		end
		for (int n = 0; n < 20; n++)
			drive_cycle(1'b0, '0, '0, irq_vec_t'(rnd(16)) | 16'h1);
		for (int rd = 0; rd < 4; rd++) begin
			mask = 4'(rnd(4));
			if (mask == '0) mask = 4'b0100;
			low = 0;
			while (!mask[low]) low++;
			drive_cycle(1'b0, '0, mask, '0);	// One-cycle pulse
			k = 0;
			do begin
				idle(1);
				k++;
			end while (chain_out !== m_vec[low] && k < 4);
			if (chain_out !== m_vec[low]) begin
				tb_err++;
				$display("Vector of line %0d did not appear within 4 cycles at %0t", low, $time);
			end
			idle(70);
		end
		write_word(11'd0, 8'h20, 64'h0000_0400_0000_0000, 1'b1);	// Interrupt disable
		drive_cycle(1'b0, '0, 4'hF, '0);
		idle(10);
		write_word(11'd0, 8'h20, '0, 1'b1);
		finish_test("irq_chain", err0);

		$display("Tests: 5, checks: %0d, errors: %0d", mon_chk, total_err());
		if (total_err() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== test/tb_monitor.sv ====
`include "ddbb_cfg_defs.svh"

module tb_monitor import ddbb_cfg_pkg::*; (
	input  logic		clk_i,
	input  logic		rst_i,
	input  cfg_resp_t	resp_i,		// DUT outputs
	input  logic [2:0]	cs_bar_i,
	input  irq_vec_t	chain_i,
	input  logic		exp_ack_i,	// Model values for the current cycle
	input  cfg_resp_t	exp_resp_i,
	input  logic [2:0]	exp_cs_i,
	input  irq_vec_t	exp_chain_i,
	output int		err_o,
	output int		chk_o,
	output int		pend_o		// Responses still in flight
);
	timeunit 1ns;
	timeprecision 100ps;

	longint		cycle;		// Edges since reset
	longint		due_q [$];	// Cycle each expected ack is due
	cfg_resp_t	rsp_q [$];

	task automatic flag(input string msg);
		err_o++;
		$display("** Error @ %0t: %s", $time, msg);
	endtask

	initial begin
		err_o = 0;
		chk_o = 0;
		pend_o = 0;
		cycle = 0;
	end

	// ==============================
	// Compare at the rising edge
	// ==============================
	always @(posedge clk_i) begin
		if (!rst_i) begin
			chk_o++;
			if (resp_i.ack) begin
				if (due_q.size() == 0) begin
					flag($sformatf("unexpected ack, tid %h adr %h", resp_i.tid, resp_i.adr));
				end else begin
					if (due_q[0] != cycle)	// Latency off
						flag($sformatf("ack at cycle %0d, due at %0d", cycle, due_q[0]));
					if (resp_i !== rsp_q[0])
						flag($sformatf("response %h, expected %h", resp_i, rsp_q[0]));
					void'(due_q.pop_front());
					void'(rsp_q.pop_front());
				end
			end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
				flag($sformatf("no ack for tid %h, due at cycle %0d", rsp_q[0].tid, due_q[0]));
				void'(due_q.pop_front());
				void'(rsp_q.pop_front());
			end
			chk_o++;
			if (cs_bar_i !== exp_cs_i)
				flag($sformatf("cs_bar %b, expected %b", cs_bar_i, exp_cs_i));
			chk_o++;
			if (chain_i !== exp_chain_i)
				flag($sformatf("irq_chain_o %h, expected %h", chain_i, exp_chain_i));
			if (exp_ack_i) begin			// Accepted this edge
				due_q.push_back(cycle + `CFG_ACK_LAT);
				rsp_q.push_back(exp_resp_i);
			end
			cycle++;
			pend_o = due_q.size();
		end
	end

endmodule
